// ==== source/colmix_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Colour mixing package
// Palette word layout, colour and pixel bundles, the Wishbone request
// bundle and the bus slave states, with every size of the colour stage
////////////////////////////////////////////////////////////////////////////

package colmix_pkg;

    // Palette memory
    localparam int PAL_AW    = 11;                  // 2048 palette entries
    localparam int PAL_DEPTH = 1 << PAL_AW;         // Words in the palette RAM
    localparam int DATA_W    = 16;                  // Bus and palette word width
    localparam int BYTE_W    = 8;                   // One byte lane
    localparam int SEL_W     = DATA_W / BYTE_W;     // Byte selects per word

    // Colour format
    localparam int COLOR_W   = 5;                   // Bits per channel
    localparam int HI_W      = COLOR_W - 1;         // High part kept in the word nibbles

    // Video pipeline
    localparam int BLANK_DLY = 2;                   // Strobes in the blanking delay line

    // Palette word as stored by the CPU, MSB first
    typedef struct packed {
        logic            exempt;                    // Set means shadow does not apply
        logic            b_lo;                      // Blue LSB
        logic            g_lo;                      // Green LSB
        logic            r_lo;                      // Red LSB
        logic [HI_W-1:0] b_hi;                      // Blue upper bits
        logic [HI_W-1:0] g_hi;                      // Green upper bits
        logic [HI_W-1:0] r_hi;                      // Red upper bits
    } pal_word_t;

    typedef struct packed {
        logic [COLOR_W-1:0] red;
        logic [COLOR_W-1:0] green;
        logic [COLOR_W-1:0] blue;
    } rgb_t;

    // One pixel with its blanking state, both flags active low
    typedef struct packed {
        rgb_t rgb;
        logic hblank_n;
        logic vblank_n;
    } pixel_t;

    // Master side of a Wishbone classic cycle
    typedef struct packed {
        logic              cyc;                     // Bus cycle in progress
        logic              stb;                     // Transfer strobe
        logic              we;                      // Write when high
        logic [SEL_W-1:0]  sel;                     // Byte enables, bit 0 is the low byte
        logic [PAL_AW-1:0] adr;                     // Word address
        logic [DATA_W-1:0] dat;                     // Write data
    } wb_req_t;

    // Bus slave FSM
    typedef enum logic [1:0] {
        st_idle,                                    // Waiting for cyc and stb
        st_read_wait,                               // RAM read in flight
        st_ack                                      // Ack cycle
    } wb_state_t;

endpackage

// ==== source/pal_ram.sv ====
////////////////////////////////////////////////////////////////////////////
// Palette RAM
// 2048 x 16 dual-port memory split in two byte lanes. The bus port
// reads and writes with byte enables, the video port only reads.
// Both read ports are registered and return old data on a collision.
////////////////////////////////////////////////////////////////////////////

module pal_ram (
    input  logic                            clk,
    // CPU side
    input  logic [colmix_pkg::PAL_AW-1:0]   bus_addr,
    input  logic [colmix_pkg::DATA_W-1:0]   bus_wdata,
    input  logic [colmix_pkg::SEL_W-1:0]    bus_we,       // One enable per byte lane
    output logic [colmix_pkg::DATA_W-1:0]   bus_rdata,
    // Video side
    input  logic [colmix_pkg::PAL_AW-1:0]   vid_addr,
    output colmix_pkg::pal_word_t           vid_data
);

    logic [colmix_pkg::DATA_W-1:0] vid_raw;               // Both lanes of the video read

    // Each lane is its own 2048 x 8 block
    for (genvar lane = 0; lane < colmix_pkg::SEL_W; lane++) begin : g_lane
        logic [colmix_pkg::BYTE_W-1:0] mem [colmix_pkg::PAL_DEPTH];
        logic [colmix_pkg::BYTE_W-1:0] bus_q;              // Bus port read register
        logic [colmix_pkg::BYTE_W-1:0] vid_q;              // Video port read register

        always_ff @(posedge clk) begin
            if (bus_we[lane]) begin
                mem[bus_addr] <= bus_wdata[lane*colmix_pkg::BYTE_W +: colmix_pkg::BYTE_W];
            end
            bus_q <= mem[bus_addr];                        // Read first, old word on write
            vid_q <= mem[vid_addr];                        // Sampled on every clock
        end

        assign bus_rdata[lane*colmix_pkg::BYTE_W +: colmix_pkg::BYTE_W] = bus_q;
        assign vid_raw[lane*colmix_pkg::BYTE_W +: colmix_pkg::BYTE_W]   = vid_q;
    end

    // Video read seen through the palette layout
    assign vid_data = colmix_pkg::pal_word_t'(vid_raw);

endmodule

// ==== source/pal_wb_slave.sv ====
////////////////////////////////////////////////////////////////////////////
// Palette bus slave
// Wishbone classic slave in front of the palette RAM. Writes ack one
// clock after the strobe, reads two clocks after it.
////////////////////////////////////////////////////////////////////////////

module pal_wb_slave (
    input  logic                            clk,
    input  logic                            rst_n,
    input  colmix_pkg::wb_req_t             wb_req,
    output logic                            wb_ack,
    output logic [colmix_pkg::DATA_W-1:0]   wb_dat_o,
    // Palette RAM bus port
    output logic [colmix_pkg::PAL_AW-1:0]   ram_addr,
    output logic [colmix_pkg::DATA_W-1:0]   ram_wdata,
    output logic [colmix_pkg::SEL_W-1:0]    ram_we,
    input  logic [colmix_pkg::DATA_W-1:0]   ram_rdata
);

    colmix_pkg::wb_state_t state;
    colmix_pkg::wb_state_t state_nxt;
    logic                  req;                            // Live request from the master

    assign req       = wb_req.cyc & wb_req.stb;
    assign ram_addr  = wb_req.adr;                         // Master holds it until ack
    assign ram_wdata = wb_req.dat;

    // Byte enables only on the accepting clock
    assign ram_we = (state == colmix_pkg::st_idle && req && wb_req.we) ? wb_req.sel : '0;

    // Ack follows the request so an aborted cycle gets none
    assign wb_ack = (state == colmix_pkg::st_ack) & req;

    always_comb begin
        state_nxt = state;
        case (state)
            colmix_pkg::st_idle: begin
                if (req) begin
                    state_nxt = wb_req.we ? colmix_pkg::st_ack : colmix_pkg::st_read_wait;
                end
            end
            colmix_pkg::st_read_wait: begin
                state_nxt = req ? colmix_pkg::st_ack : colmix_pkg::st_idle; // Drop on abort
            end
            colmix_pkg::st_ack: state_nxt = colmix_pkg::st_idle; // Single ack per cycle
            default:            state_nxt = colmix_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= colmix_pkg::st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // RAM output settles during read_wait, held through ack
    always_ff @(posedge clk) begin
        if (state == colmix_pkg::st_read_wait) begin
            wb_dat_o <= ram_rdata;
        end
    end

endmodule

// ==== source/pal_shade.sv ====
////////////////////////////////////////////////////////////////////////////
// Palette shading
// Unpacks the palette word into RGB, dims it under shadow unless the
// word is exempt, blacks it out while video is off and registers the
// pixel with its blanking flags on the pixel strobe
////////////////////////////////////////////////////////////////////////////

module pal_shade (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pix_cen,          // One clock per pixel
    input  colmix_pkg::pal_word_t   pal_word,         // Registered RAM output
    input  logic                    shadow,
    input  logic                    video_en,
    input  logic                    pre_hblank_n,
    input  logic                    pre_vblank_n,
    output colmix_pkg::pixel_t      pix
);

    colmix_pkg::rgb_t raw;                              // Unpacked palette colour
    colmix_pkg::rgb_t shaded;                           // After shadow rule
    colmix_pkg::rgb_t gated;                            // After video enable
    logic             dim_en;

    // Shadow darkens by a quarter
    function automatic logic [colmix_pkg::COLOR_W-1:0] dim(
        input logic [colmix_pkg::COLOR_W-1:0] a
    );
        return a - (a >> 2);
    endfunction

    // High nibble then the shared LSB
    assign raw.red   = {pal_word.r_hi, pal_word.r_lo};
    assign raw.green = {pal_word.g_hi, pal_word.g_lo};
    assign raw.blue  = {pal_word.b_hi, pal_word.b_lo};

    assign dim_en = shadow & ~pal_word.exempt;          // Exempt words ignore shadow

    always_comb begin
        shaded = raw;
        if (dim_en) begin
            shaded.red   = dim(raw.red);
            shaded.green = dim(raw.green);
            shaded.blue  = dim(raw.blue);
        end
        gated = video_en ? shaded : '0;                 // Black while video is off
    end

    // Colour and blanking move together from here on
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pix <= '0;                                  // Black and blanked
        end else if (pix_cen) begin
            pix.rgb      <= gated;
            pix.hblank_n <= pre_hblank_n;
            pix.vblank_n <= pre_vblank_n;
        end
    end

endmodule

// ==== source/blank_delay.sv ====
////////////////////////////////////////////////////////////////////////////
// Blanking delay line
// Shifts colour and blanking together by BLANK_DLY pixel strobes and
// shows black on the output while either blank is active
////////////////////////////////////////////////////////////////////////////

module blank_delay (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pix_cen,
    input  colmix_pkg::pixel_t  pix_in,
    output colmix_pkg::pixel_t  pix_out
);

    colmix_pkg::pixel_t dly [colmix_pkg::BLANK_DLY];    // dly[0] is the newest pixel
    colmix_pkg::pixel_t last;                           // Output stage
    logic               visible;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < colmix_pkg::BLANK_DLY; i++) begin
                dly[i] <= '0;                           // Line starts blanked
            end
        end else if (pix_cen) begin
            dly[0] <= pix_in;
            for (int i = 1; i < colmix_pkg::BLANK_DLY; i++) begin
                dly[i] <= dly[i-1];                     // Advance one pixel
            end
        end
    end

    assign last    = dly[colmix_pkg::BLANK_DLY-1];
    assign visible = last.hblank_n & last.vblank_n;     // Both blanks inactive

    // Flags pass as they are, colour only in the active area
    always_comb begin
        pix_out          = last;
        pix_out.rgb      = visible ? last.rgb : '0;
    end

endmodule

// ==== source/video_colmix.sv ====
////////////////////////////////////////////////////////////////////////////
// Colour mixing top
// CPU palette writes come in over Wishbone, the video side looks up
// one palette word per pixel. Colour and blanking leave the block
// three pixel strobes after they are presented.
////////////////////////////////////////////////////////////////////////////

module video_colmix (
    input  logic                            clk,
    input  logic                            rst_n,
    // CPU bus
    input  colmix_pkg::wb_req_t             wb_req,
    output logic                            wb_ack,
    output logic [colmix_pkg::DATA_W-1:0]   wb_dat_o,
    // Video input
    input  logic                            pix_cen,      // Pixel strobe
    input  logic                            video_en,
    input  logic                            pre_hblank_n,
    input  logic                            pre_vblank_n,
    input  logic [colmix_pkg::PAL_AW-1:0]   pal_addr,     // Stable a clock before pix_cen
    input  logic                            shadow,
    // Video output
    output logic [colmix_pkg::COLOR_W-1:0]  red,
    output logic [colmix_pkg::COLOR_W-1:0]  green,
    output logic [colmix_pkg::COLOR_W-1:0]  blue,
    output logic                            hblank_n,
    output logic                            vblank_n
);

    logic [colmix_pkg::PAL_AW-1:0] ram_addr;
    logic [colmix_pkg::DATA_W-1:0] ram_wdata;
    logic [colmix_pkg::SEL_W-1:0]  ram_we;
    logic [colmix_pkg::DATA_W-1:0] ram_rdata;
    colmix_pkg::pal_word_t         pal_word;            // Video read of the palette
    colmix_pkg::pixel_t            shade_pix;           // Shaded pixel, first strobe
    colmix_pkg::pixel_t            out_pix;             // After the delay line

    pal_wb_slave u_wb (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .wb_req    ( wb_req    ),
        .wb_ack    ( wb_ack    ),
        .wb_dat_o  ( wb_dat_o  ),
        .ram_addr  ( ram_addr  ),
        .ram_wdata ( ram_wdata ),
        .ram_we    ( ram_we    ),
        .ram_rdata ( ram_rdata )
    );

    pal_ram u_ram (
        .clk       ( clk       ),
        .bus_addr  ( ram_addr  ),
        .bus_wdata ( ram_wdata ),
        .bus_we    ( ram_we    ),
        .bus_rdata ( ram_rdata ),
        .vid_addr  ( pal_addr  ),
        .vid_data  ( pal_word  )
    );

    pal_shade u_shade (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .pix_cen      ( pix_cen      ),
        .pal_word     ( pal_word     ),
        .shadow       ( shadow       ),
        .video_en     ( video_en     ),
        .pre_hblank_n ( pre_hblank_n ),
        .pre_vblank_n ( pre_vblank_n ),
        .pix          ( shade_pix    )
    );

    blank_delay u_blank (
        .clk     ( clk       ),
        .rst_n   ( rst_n     ),
        .pix_cen ( pix_cen   ),
        .pix_in  ( shade_pix ),
        .pix_out ( out_pix   )
    );

    // Final pixel out to the ports
    assign red      = out_pix.rgb.red;
    assign green    = out_pix.rgb.green;
    assign blue     = out_pix.rgb.blue;
    assign hblank_n = out_pix.hblank_n;
    assign vblank_n = out_pix.vblank_n;

endmodule

// ==== bench/colmix_assert.sv ====
////////////////////////////////////////////////////////////////////////////
// Colour mixing assertions
// Wishbone ack rules and black colour during blanking, bound into
// the colour mixing top
////////////////////////////////////////////////////////////////////////////

module colmix_assert (
    input logic                             clk,
    input logic                             rst_n,
    input colmix_pkg::wb_req_t              wb_req,
    input logic                             wb_ack,
    input logic [colmix_pkg::COLOR_W-1:0]   red,
    input logic [colmix_pkg::COLOR_W-1:0]   green,
    input logic [colmix_pkg::COLOR_W-1:0]   blue,
    input logic                             hblank_n,
    input logic                             vblank_n
);
    timeunit 1ns;
    timeprecision 1ns;

    // Ack only inside a live request
    ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> (wb_req.cyc && wb_req.stb))
        else $error("wb_ack high without cyc and stb");

    // One ack per transfer
    ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high on two clocks in a row");

    // Nothing visible while either blank is active
    black_in_blank: assert property (@(posedge clk) disable iff (!rst_n)
        (!hblank_n || !vblank_n) |-> (red == '0 && green == '0 && blue == '0))
        else $error("colour not black during blanking");

endmodule

// ==== bench/colmix_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Colour mixing testbench
// Fills the palette over Wishbone, checks the byte lanes by read back,
// then streams random pixels and compares the video outputs against
// a palette and pipeline model
////////////////////////////////////////////////////////////////////////////

module colmix_tb;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int ACK_TIMEOUT = 16;                     // Clocks to wait for ack

    logic                               clk;
    logic                               rst_n;
    colmix_pkg::wb_req_t                wb_req;
    logic                               wb_ack;
    logic [colmix_pkg::DATA_W-1:0]      wb_dat_o;
    logic                               pix_cen;
    logic                               video_en;
    logic                               pre_hblank_n;
    logic                               pre_vblank_n;
    logic [colmix_pkg::PAL_AW-1:0]      pal_addr;
    logic                               shadow;
    logic [colmix_pkg::COLOR_W-1:0]     red;
    logic [colmix_pkg::COLOR_W-1:0]     green;
    logic [colmix_pkg::COLOR_W-1:0]     blue;
    logic                               hblank_n;
    logic                               vblank_n;

    logic [colmix_pkg::DATA_W-1:0]      model_pal [colmix_pkg::PAL_DEPTH]; // CPU view of palette
    colmix_pkg::pixel_t                 exp_q [$];       // Pixels in flight, oldest first
    int                                 value_errors;
    int                                 timeouts;

    video_colmix uut (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .wb_req       ( wb_req       ),
        .wb_ack       ( wb_ack       ),
        .wb_dat_o     ( wb_dat_o     ),
        .pix_cen      ( pix_cen      ),
        .video_en     ( video_en     ),
        .pre_hblank_n ( pre_hblank_n ),
        .pre_vblank_n ( pre_vblank_n ),
        .pal_addr     ( pal_addr     ),
        .shadow       ( shadow       ),
        .red          ( red          ),
        .green        ( green        ),
        .blue         ( blue         ),
        .hblank_n     ( hblank_n     ),
        .vblank_n     ( vblank_n     )
    );

    bind video_colmix colmix_assert u_assert (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .wb_req   ( wb_req   ),
        .wb_ack   ( wb_ack   ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .hblank_n ( hblank_n ),
        .vblank_n ( vblank_n )
    );

    always #20 clk = ~clk;                               // 40 ns period

    task automatic check_word(input string name, input logic [colmix_pkg::DATA_W-1:0] exp,
                              input logic [colmix_pkg::DATA_W-1:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_rgb(input string name, input colmix_pkg::rgb_t exp,
                             input colmix_pkg::rgb_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %0t ns: %s expected r%0d g%0d b%0d, got r%0d g%0d b%0d",
                     $time, name, exp.red, exp.green, exp.blue, act.red, act.green, act.blue);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_pixel(input colmix_pkg::pixel_t exp, input colmix_pkg::pixel_t act);
        check_rgb("rgb", exp.rgb, act.rgb);
        check_flag("hblank_n", exp.hblank_n, act.hblank_n);
        check_flag("vblank_n", exp.vblank_n, act.vblank_n);
    endtask

    // Byte lanes of a write land on top of the old word
    function automatic logic [colmix_pkg::DATA_W-1:0] merge_bytes(
        input logic [colmix_pkg::DATA_W-1:0] old_w,
        input logic [colmix_pkg::DATA_W-1:0] new_w,
        input logic [colmix_pkg::SEL_W-1:0]  sel
    );
        logic [colmix_pkg::DATA_W-1:0] w;
        w = old_w;
        if (sel[0]) w[7:0] = new_w[7:0];                 // Low byte
        if (sel[1]) w[15:8] = new_w[15:8];               // High byte
        return w;
    endfunction

    // Expected output pixel for one palette word and its video inputs
    function automatic colmix_pkg::pixel_t model_pixel(
        input logic [colmix_pkg::DATA_W-1:0] w,
        input logic sh,
        input logic ven,
        input logic hb,
        input logic vb
    );
        colmix_pkg::pixel_t p;
        logic [4:0] r;
        logic [4:0] g;
        logic [4:0] b;
        r = {w[3:0], w[12]};                             // High nibble, then the LSB
        g = {w[7:4], w[13]};
        b = {w[11:8], w[14]};
        if (sh && !w[15]) begin                          // Bit 15 set keeps full brightness
            r = r - (r >> 2);
            g = g - (g >> 2);
            b = b - (b >> 2);
        end
        if (!ven || !hb || !vb) begin                    // Video off or blanked
            r = '0;
            g = '0;
            b = '0;
        end
        p.rgb.red   = r;
        p.rgb.green = g;
        p.rgb.blue  = b;
        p.hblank_n  = hb;
        p.vblank_n  = vb;
        return p;
    endfunction

    function automatic colmix_pkg::pixel_t output_pixel();
        colmix_pkg::pixel_t p;
        p.rgb.red   = red;
        p.rgb.green = green;
        p.rgb.blue  = blue;
        p.hblank_n  = hblank_n;
        p.vblank_n  = vblank_n;
        return p;
    endfunction

    // Starts just after a rising edge, leaves just after the ack edge
    task automatic wait_ack(input string what);
        int n;
        n = 0;
        while (wb_ack !== 1'b1 && n < ACK_TIMEOUT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (wb_ack !== 1'b1) begin
            timeouts++;
            $display("Timeout at %0t ns: the bus %s got no ack", $time, what);
        end
    endtask

    task automatic bus_write(input logic [colmix_pkg::PAL_AW-1:0] adr,
                             input logic [colmix_pkg::DATA_W-1:0] dat,
                             input logic [colmix_pkg::SEL_W-1:0]  sel);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b1;
        wb_req.sel = sel;
        wb_req.adr = adr;
        wb_req.dat = dat;
        wait_ack("write");
        @(posedge clk);                                  // Master samples ack here
        #2;
        check_flag("wb_ack", 1'b0, wb_ack);              // Ack lasts one clock, stb still high
        wb_req = '0;
        model_pal[adr] = merge_bytes(model_pal[adr], dat, sel);
    endtask

    task automatic bus_read(input logic [colmix_pkg::PAL_AW-1:0] adr,
                            output logic [colmix_pkg::DATA_W-1:0] dat);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b0;
        wb_req.sel = 2'b11;
        wb_req.adr = adr;
        wait_ack("read");
        dat = wb_dat_o;                                  // Valid while ack is high
        @(posedge clk);
        #2;
        check_flag("wb_ack", 1'b0, wb_ack);
        wb_req = '0;
    endtask

    // Address one clock ahead, then the strobe; checks the pixel leaving the pipe
    task automatic drive_pixel(input logic [colmix_pkg::PAL_AW-1:0] addr,
                               input logic sh, input logic ven,
                               input logic hb, input logic vb);
        colmix_pkg::pixel_t exp;
        pal_addr     = addr;
        shadow       = sh;
        video_en     = ven;
        pre_hblank_n = hb;
        pre_vblank_n = vb;
        @(posedge clk);
        #2;
        pix_cen = 1'b1;
        @(posedge clk);                                  // Strobe edge
        #2;
        pix_cen = 1'b0;
        exp_q.push_back(model_pixel(model_pal[addr], sh, ven, hb, vb));
        exp = exp_q.pop_front();                         // Presented two strobes back
        check_pixel(exp, output_pixel());
    endtask

    // Mode 0 plain, 1 shadow, 2 video off, 3 blanking
    task automatic stream_pixels(input int mode, input int count);
        logic [31:0] rnd;
        for (int n = 0; n < count; n++) begin
            rnd = $urandom;
            case (mode)
                0:       drive_pixel(rnd[10:0], 1'b0, 1'b1, 1'b1, 1'b1);
                1:       drive_pixel(rnd[10:0], rnd[11], 1'b1, 1'b1, 1'b1);
                2:       drive_pixel(rnd[10:0], rnd[11], |rnd[13:12], 1'b1, 1'b1);
                default: drive_pixel(rnd[10:0], rnd[11], |rnd[13:12], |rnd[15:14],
                                     |rnd[17:16]);       // About one in four blanked
            endcase
        end
    endtask

    initial begin
        logic [31:0]                   rnd;
        logic [colmix_pkg::DATA_W-1:0] rd;
        void'($urandom(47));
        clk          = 1'b0;
        rst_n        = 1'b0;
        wb_req       = '0;
        pix_cen      = 1'b0;
        video_en     = 1'b0;
        pre_hblank_n = 1'b0;
        pre_vblank_n = 1'b0;
        pal_addr     = '0;
        shadow       = 1'b0;
        value_errors = 0;
        timeouts     = 0;
        exp_q.push_back('0);                             // Delay line after reset
        exp_q.push_back('0);
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_flag("wb_ack", 1'b0, wb_ack);
        check_pixel('0, output_pixel());                 // Black and blanked
        for (int a = 0; a < colmix_pkg::PAL_DEPTH; a++) begin
            rnd = $urandom;
            bus_write(a[10:0], rnd[15:0], 2'b11);        // Whole palette gets known contents
        end
        for (int n = 0; n < 64; n++) begin
            rnd = $urandom;
            bus_write(rnd[10:0], rnd[31:16], rnd[12:11]);
            bus_read(rnd[10:0], rd);
            check_word("wb_dat_o", model_pal[rnd[10:0]], rd);
        end
        stream_pixels(0, 40);
        stream_pixels(1, 60);
        stream_pixels(2, 60);
        stream_pixels(3, 80);
        stream_pixels(0, 2);                             // Flush the last blanked pixels
        $display("Checks done: %0d value errors, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== video_colmix.f ====
source/colmix_pkg.sv
source/pal_ram.sv
source/pal_wb_slave.sv
source/pal_shade.sv
source/blank_delay.sv
source/video_colmix.sv
bench/colmix_assert.sv
bench/colmix_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the colour mixing stage

VERILATOR  ?= verilator
TOP        ?= colmix_tb
RTL_TOP    ?= video_colmix
FILELIST   ?= video_colmix.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ns
LINT_FLAGS ?= --lint-only -Wall
FAIL_MSG   ?= TEST RESULT: FAIL
PASS_MSG   ?= TEST RESULT: PASS

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter source/%,$(SRCS))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
